//--- files.f
rtl/axi_xing_pkg.sv
rtl/axi_link_if.sv
rtl/async_fifo.sv
rtl/axi_axi_bridge.sv
rtl/axi_burst_mem.sv
rtl/axi_xing_top.sv
verif/tb_axi_xing.sv

//--- verif/tb_axi_xing.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the AXI clock crossing subsystem
// Applies a table of write and read bursts to i_dut
// Read beats are checked against a reference word array
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module tb_axi_xing import axi_xing_pkg::*; ();

	localparam int TB_MEM_WORDS  = 64;
	localparam int TB_DATA_DEPTH = 8;
	localparam int N_ROWS        = 12;
	localparam int EXTRA_TICKS   = 10; // Quiet window to catch duplicates

	typedef enum logic {OP_WR, OP_RD} op_t;

	typedef struct packed {
		op_t   op;
		addr_t addr;     // Word address
		len_t  len;      // Beats minus one
		data_t seed;     // Mixed into beat data
		logic  throttle; // Random bready/rready stalls
	} row_t;

	localparam row_t TABLE [N_ROWS] = '{
		'{OP_WR, 32'd5,   8'd0,  32'h0000_1111, 1'b0}, // Single beat
		'{OP_RD, 32'd5,   8'd0,  32'h0,         1'b0},
		'{OP_WR, 32'd16,  8'd15, 32'hA5A5_0000, 1'b0}, // Longer than w FIFO
		'{OP_RD, 32'd16,  8'd15, 32'h0,         1'b0},
		'{OP_RD, 32'd16,  8'd15, 32'h0,         1'b1}, // Same burst with stalls
		'{OP_WR, 32'd61,  8'd7,  32'h0000_0000, 1'b1}, // Wraps past word 63
		'{OP_RD, 32'd0,   8'd4,  32'h0,         1'b0}, // Wrapped words from 0
		'{OP_RD, 32'd125, 8'd7,  32'h0,         1'b1}, // 125 mod 64 is 61
		'{OP_WR, 32'd8,   8'd7,  32'h0F0F_0F0F, 1'b0},
		'{OP_WR, 32'd12,  8'd7,  32'hF0F0_F0F0, 1'b0}, // Overlaps 12..15
		'{OP_RD, 32'd8,   8'd11, 32'h0,         1'b0},
		'{OP_RD, 32'd5,   8'd0,  32'h0,         1'b1}
	};

	logic  arst_n;
	logic  clk_s;
	logic  clk_m;
	addr_t axi_awaddr;
	len_t  axi_awlen;
	logic  axi_awvalid;
	logic  axi_awready;
	data_t axi_wdata;
	logic  axi_wlast;
	logic  axi_wvalid;
	logic  axi_wready;
	logic  axi_bvalid;
	logic  axi_bready;
	addr_t axi_araddr;
	len_t  axi_arlen;
	logic  axi_arvalid;
	logic  axi_arready;
	data_t axi_rdata;
	logic  axi_rvalid;
	logic  axi_rready;

	data_t       ref_mem [TB_MEM_WORDS]; // Expected memory contents
	logic [31:0] rng_state;
	int          b_total;                // All b responses seen

	axi_xing_top #(
		.DATA_FIFO_DEPTH (TB_DATA_DEPTH),
		.MEM_WORDS       (TB_MEM_WORDS)
	) i_dut (.*);

	initial begin
		clk_s = 1'b0;
		forever #50 clk_s = ~clk_s; // 100 ns
	end

	initial begin
		clk_m = 1'b0;
		forever #35 clk_m = ~clk_m; // 70 ns with rises off the clk_s rises
	end

	// Every b handshake over the whole run, late strays included
	always @(posedge clk_s) begin
		if (axi_bvalid && axi_bready)
			b_total++;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] next_rand();
		rng_state = xorshift(rng_state);
		return rng_state;
	endfunction

	// Ready low about one cycle in four when throttled
	function automatic logic pick_ready(input logic throttle);
		logic [31:0] r;
		if (!throttle)
			return 1'b1;
		r = next_rand();
		return r[1:0] != 2'b00;
	endfunction

	// Step to the drive point just after the rising edge
	task automatic tick();
		@(posedge clk_s);
		#5;
	endtask

	task automatic check_data(input string name, input data_t exp, input data_t got);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s expected %h received %h", $time, name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1, "Data mismatch");
		end
	endtask

	task automatic check_count(input string name, input len_t exp, input len_t got);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s expected %0d received %0d", $time, name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1, "Count mismatch");
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			$display("[ERROR] %0t ns %s expected %b received %b", $time, name, exp, got);
			$display("SOME TESTS FAILED");
			$fatal(1, "Flag mismatch");
		end
	endtask

	task automatic write_burst(input row_t row);
		int    i;
		int    b_seen;
		logic  ok;
		data_t beat;
		axi_awaddr  = row.addr;
		axi_awlen   = row.len;
		axi_awvalid = 1'b1;
		ok = 1'b0;
		while (!ok) begin
			ok = axi_awready; // Ready held until the next edge
			tick();
		end
		axi_awvalid = 1'b0;
		for (i = 0; i <= row.len; i++) begin
			beat = next_rand() ^ row.seed;
			ref_mem[(row.addr + i) % TB_MEM_WORDS] = beat;
			axi_wdata  = beat;
			axi_wlast  = (i == row.len);
			axi_wvalid = 1'b1;
			ok = 1'b0;
			while (!ok) begin
				ok = axi_wready; // Low while the w FIFO is full
				tick();
			end
		end
		axi_wvalid = 1'b0;
		axi_wlast  = 1'b0;
		b_seen = 0;
		while (b_seen == 0) begin
			axi_bready = pick_ready(row.throttle);
			if (axi_bvalid && axi_bready)
				b_seen++;
			tick();
		end
		axi_bready = 1'b1;
		repeat (EXTRA_TICKS) begin
			if (axi_bvalid)
				b_seen++; // Duplicate token
			tick();
		end
		check_count("axi_bvalid responses", len_t'(1), len_t'(b_seen));
	endtask

	task automatic read_burst(input row_t row);
		int   got;
		logic ok;
		axi_araddr  = row.addr;
		axi_arlen   = row.len;
		axi_arvalid = 1'b1;
		ok = 1'b0;
		while (!ok) begin
			ok = axi_arready;
			tick();
		end
		axi_arvalid = 1'b0;
		got = 0;
		while (got <= row.len) begin
			axi_rready = pick_ready(row.throttle);
			if (axi_rvalid && axi_rready) begin // Taken on the coming edge
				check_data("axi_rdata", ref_mem[(row.addr + got) % TB_MEM_WORDS], axi_rdata);
				got++;
			end
			tick();
		end
		axi_rready = 1'b1;
		repeat (EXTRA_TICKS) begin
			if (axi_rvalid)
				got++;
			tick();
		end
		check_count("axi_rvalid beats", len_t'(row.len + 1), len_t'(got));
	endtask

	// Main sequence
	initial begin
		int n_writes;
		rng_state   = 32'd10;
		b_total     = 0;
		n_writes    = 0;
		arst_n      = 1'b0;
		axi_awaddr  = '0;
		axi_awlen   = '0;
		axi_awvalid = 1'b0;
		axi_wdata   = '0;
		axi_wlast   = 1'b0;
		axi_wvalid  = 1'b0;
		axi_bready  = 1'b1;
		axi_araddr  = '0;
		axi_arlen   = '0;
		axi_arvalid = 1'b0;
		axi_rready  = 1'b1;
		repeat (2) @(posedge clk_s);
		#5 arst_n = 1'b1;
		tick();
		tick();
		check_flag("axi_bvalid", 1'b0, axi_bvalid);
		check_flag("axi_rvalid", 1'b0, axi_rvalid);
		check_flag("axi_awready", 1'b1, axi_awready);
		check_flag("axi_wready", 1'b1, axi_wready);
		check_flag("axi_arready", 1'b1, axi_arready);
		for (int r = 0; r < N_ROWS; r++) begin
			if (TABLE[r].op == OP_WR) begin
				n_writes++;
				write_burst(TABLE[r]);
			end else begin
				read_burst(TABLE[r]);
			end
		end
		check_count("total b responses", len_t'(n_writes), len_t'(b_total));
		$display("ALL TESTS PASSED");
		$finish;
	end

	// Watchdog allows 40 clk_s cycles per beat plus a margin
	initial begin
		longint limit_ns;
		limit_ns = 10000;
		for (int r = 0; r < N_ROWS; r++)
			limit_ns += (longint'(TABLE[r].len) + 1) * 40 * 100;
		#(limit_ns);
		$display("Watchdog expired, the DUT stopped responding before the table finished");
		$display("SOME TESTS FAILED");
		$fatal(1, "Timeout");
	end

endmodule

//--- rtl/axi_xing_top.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Top of the AXI clock crossing subsystem
// Plain AXI slave ports on clk_s
// Bridge into a burst memory on clk_m
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axi_xing_top import axi_xing_pkg::*; #(
	parameter int CTRL_FIFO_DEPTH = axi_xing_pkg::CTRL_FIFO_DEPTH,
	parameter int DATA_FIFO_DEPTH = axi_xing_pkg::DATA_FIFO_DEPTH,
	parameter int MEM_WORDS       = axi_xing_pkg::MEM_WORDS
) (
	input  logic  arst_n,
	input  logic  clk_s,       // Master side
	input  logic  clk_m,       // Memory side
	input  addr_t axi_awaddr,
	input  len_t  axi_awlen,
	input  logic  axi_awvalid,
	output logic  axi_awready,
	input  data_t axi_wdata,
	input  logic  axi_wlast,
	input  logic  axi_wvalid,
	output logic  axi_wready,
	output logic  axi_bvalid,
	input  logic  axi_bready,
	input  addr_t axi_araddr,
	input  len_t  axi_arlen,
	input  logic  axi_arvalid,
	output logic  axi_arready,
	output data_t axi_rdata,
	output logic  axi_rvalid,
	input  logic  axi_rready
);
	axi_link_if i_link (.clk(clk_m), .arst_n(arst_n)); // clk_m side link

	axi_axi_bridge #(
		.ADDR_WIDTH      (ADDR_W),
		.DATA_WIDTH      (DATA_W),
		.CTRL_FIFO_DEPTH (CTRL_FIFO_DEPTH),
		.DATA_FIFO_DEPTH (DATA_FIFO_DEPTH)
	) i_bridge (
		.arst_n        (arst_n),
		.clk_s         (clk_s),
		.axi_awaddr_s  (axi_awaddr),
		.axi_awlen_s   (axi_awlen),
		.axi_awvalid_s (axi_awvalid),
		.axi_awready_s (axi_awready),
		.axi_wdata_s   (axi_wdata),
		.axi_wlast_s   (axi_wlast),
		.axi_wvalid_s  (axi_wvalid),
		.axi_wready_s  (axi_wready),
		.axi_bvalid_s  (axi_bvalid),
		.axi_bready_s  (axi_bready),
		.axi_araddr_s  (axi_araddr),
		.axi_arlen_s   (axi_arlen),
		.axi_arvalid_s (axi_arvalid),
		.axi_arready_s (axi_arready),
		.axi_rdata_s   (axi_rdata),
		.axi_rvalid_s  (axi_rvalid),
		.axi_rready_s  (axi_rready),
		.m             (i_link.mst)
	);

	axi_burst_mem #(.MEM_WORDS(MEM_WORDS)) i_mem (.s(i_link.slv));

endmodule

//--- rtl/axi_burst_mem.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI burst memory slave on the link
// Write bursts land in a word array
// Read bursts stream arlen+1 words back
// Addresses wrap modulo MEM_WORDS
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axi_burst_mem import axi_xing_pkg::*; #(
	parameter int MEM_WORDS = axi_xing_pkg::MEM_WORDS
) (
	axi_link_if.slv s
);
	localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;

	typedef logic [IDX_W-1:0] idx_t; // Array word index

	typedef enum logic [1:0] {
		WR_IDLE,
		WR_DATA,
		WR_RESP
	} wr_state_t;

	typedef enum logic {
		RD_IDLE,
		RD_DATA
	} rd_state_t;

	data_t     mem [MEM_WORDS];
	wr_state_t wr_state;
	idx_t      wr_idx;     // Next word to write
	len_t      wr_len;     // Captured awlen
	len_t      wr_cnt;     // Beats taken so far
	rd_state_t rd_state;
	idx_t      rd_idx;     // Word on rdata
	len_t      rd_left;    // Beats after this one

	// Step one word with wrap
	function automatic idx_t next_idx(input idx_t i);
		return (i == idx_t'(MEM_WORDS - 1)) ? '0 : i + 1'b1;
	endfunction

	// Write FSM
	assign s.awready = (wr_state == WR_IDLE);
	assign s.wready  = (wr_state == WR_DATA);
	assign s.bvalid  = (wr_state == WR_RESP);

	always_ff @(posedge s.clk or negedge s.arst_n) begin
		if (!s.arst_n) begin
			wr_state <= WR_IDLE;
			wr_idx   <= '0;
			wr_len   <= '0;
			wr_cnt   <= '0;
		end else begin
			case (wr_state)
				WR_IDLE: begin
					if (s.awvalid) begin
						wr_idx   <= idx_t'(s.awaddr % MEM_WORDS);
						wr_len   <= s.awlen;
						wr_cnt   <= '0;
						wr_state <= WR_DATA;
					end
				end
				WR_DATA: begin
					if (s.wvalid) begin
						wr_idx <= next_idx(wr_idx);
						wr_cnt <= wr_cnt + 1'b1;
						if (s.wlast)
							wr_state <= WR_RESP; // bvalid on next edge
					end
				end
				WR_RESP: begin
					if (s.bready)
						wr_state <= WR_IDLE;
				end
				default: wr_state <= WR_IDLE;
			endcase
		end
	end

	always_ff @(posedge s.clk) begin
		if (s.wvalid && s.wready)
			mem[wr_idx] <= s.wdata;
	end

	// Read FSM, independent of the write side
	assign s.arready = (rd_state == RD_IDLE);
	assign s.rvalid  = (rd_state == RD_DATA);
	assign s.rdata   = mem[rd_idx];   // Old value on same-cycle write

	always_ff @(posedge s.clk or negedge s.arst_n) begin
		if (!s.arst_n) begin
			rd_state <= RD_IDLE;
			rd_idx   <= '0;
			rd_left  <= '0;
		end else begin
			case (rd_state)
				RD_IDLE: begin
					if (s.arvalid) begin
						rd_idx   <= idx_t'(s.araddr % MEM_WORDS);
						rd_left  <= s.arlen;
						rd_state <= RD_DATA;
					end
				end
				RD_DATA: begin
					if (s.rready) begin   // Beat taken
						rd_idx  <= next_idx(rd_idx);
						rd_left <= rd_left - 1'b1;
						if (rd_left == '0)
							rd_state <= RD_IDLE;
					end
				end
				default: rd_state <= RD_IDLE;
			endcase
		end
	end

	// Burst framing from the far side of the bridge
	a_wlast_on_len: assert property (@(posedge s.clk) disable iff (!s.arst_n)
		s.wvalid && s.wready |-> (s.wlast == (wr_cnt == wr_len)))
		else $error("wlast not on beat awlen+1");

endmodule

//--- rtl/axi_axi_bridge.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Asynchronous AXI to AXI bridge
// Slave ports on clk_s, master link on clk_m
// Each of the five channels has its own FIFO
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module axi_axi_bridge import axi_xing_pkg::*; #(
	parameter int ADDR_WIDTH      = ADDR_W,
	parameter int DATA_WIDTH      = DATA_W,
	parameter int CTRL_FIFO_DEPTH = axi_xing_pkg::CTRL_FIFO_DEPTH,
	parameter int DATA_FIFO_DEPTH = axi_xing_pkg::DATA_FIFO_DEPTH
) (
	input  logic  arst_n,
	input  logic  clk_s,
	input  addr_t axi_awaddr_s,  // Write address
	input  len_t  axi_awlen_s,
	input  logic  axi_awvalid_s,
	output logic  axi_awready_s,
	input  data_t axi_wdata_s,   // Write data
	input  logic  axi_wlast_s,
	input  logic  axi_wvalid_s,
	output logic  axi_wready_s,
	output logic  axi_bvalid_s,  // Write response
	input  logic  axi_bready_s,
	input  addr_t axi_araddr_s,  // Read address
	input  len_t  axi_arlen_s,
	input  logic  axi_arvalid_s,
	output logic  axi_arready_s,
	output data_t axi_rdata_s,   // Read data
	output logic  axi_rvalid_s,
	input  logic  axi_rready_s,
	axi_link_if.mst m            // Toward the memory, clk_m
);
	localparam int LEN_W  = $bits(len_t);
	localparam int CMD_W  = ADDR_WIDTH + LEN_W; // Address plus length
	localparam int WDAT_W = DATA_WIDTH + 1;     // Data plus last

	if (ADDR_WIDTH != ADDR_W || DATA_WIDTH != DATA_W) begin : g_width_check
		$fatal(1, "axi_axi_bridge widths must match the package defaults");
	end

	logic             aw_full;
	logic             aw_empty;
	logic [CMD_W-1:0] aw_head;
	logic              w_full;
	logic              w_empty;
	logic [WDAT_W-1:0] w_head;
	logic             b_full;
	logic             b_empty;
	logic             ar_full;
	logic             ar_empty;
	logic [CMD_W-1:0] ar_head;
	logic             r_full;
	logic             r_empty;

	// aw, clk_s to clk_m
	async_fifo #(.WIDTH(CMD_W), .DEPTH(CTRL_FIFO_DEPTH)) i_aw_fifo (
		.arst_n  (arst_n),
		.wr_clk  (clk_s),
		.wr_en   (axi_awvalid_s && axi_awready_s),
		.wr_data ({axi_awaddr_s, axi_awlen_s}),
		.full    (aw_full),
		.rd_clk  (m.clk),
		.rd_en   (m.awvalid && m.awready),
		.rd_data (aw_head),
		.empty   (aw_empty)
	);
	assign axi_awready_s       = !aw_full;
	assign m.awvalid           = !aw_empty;
	assign {m.awaddr, m.awlen} = aw_head;

	// w, same direction, deeper
	async_fifo #(.WIDTH(WDAT_W), .DEPTH(DATA_FIFO_DEPTH)) i_w_fifo (
		.arst_n  (arst_n),
		.wr_clk  (clk_s),
		.wr_en   (axi_wvalid_s && axi_wready_s),
		.wr_data ({axi_wdata_s, axi_wlast_s}),
		.full    (w_full),
		.rd_clk  (m.clk),
		.rd_en   (m.wvalid && m.wready),
		.rd_data (w_head),
		.empty   (w_empty)
	);
	assign axi_wready_s       = !w_full;
	assign m.wvalid           = !w_empty;
	assign {m.wdata, m.wlast} = w_head;

	// b, one token per completed burst back to clk_s
	async_fifo #(.WIDTH(1), .DEPTH(CTRL_FIFO_DEPTH)) i_b_fifo (
		.arst_n  (arst_n),
		.wr_clk  (m.clk),
		.wr_en   (m.bvalid && m.bready),
		.wr_data (1'b1),
		.full    (b_full),
		.rd_clk  (clk_s),
		.rd_en   (axi_bvalid_s && axi_bready_s),
		.rd_data (),          // Token carries no code
		.empty   (b_empty)
	);
	assign m.bready     = !b_full;   // Memory holds bvalid while full
	assign axi_bvalid_s = !b_empty;

	// ar, clk_s to clk_m
	async_fifo #(.WIDTH(CMD_W), .DEPTH(CTRL_FIFO_DEPTH)) i_ar_fifo (
		.arst_n  (arst_n),
		.wr_clk  (clk_s),
		.wr_en   (axi_arvalid_s && axi_arready_s),
		.wr_data ({axi_araddr_s, axi_arlen_s}),
		.full    (ar_full),
		.rd_clk  (m.clk),
		.rd_en   (m.arvalid && m.arready),
		.rd_data (ar_head),
		.empty   (ar_empty)
	);
	assign axi_arready_s       = !ar_full;
	assign m.arvalid           = !ar_empty;
	assign {m.araddr, m.arlen} = ar_head;

	// r, back to clk_s
	async_fifo #(.WIDTH(DATA_WIDTH), .DEPTH(DATA_FIFO_DEPTH)) i_r_fifo (
		.arst_n  (arst_n),
		.wr_clk  (m.clk),
		.wr_en   (m.rvalid && m.rready),
		.wr_data (m.rdata),
		.full    (r_full),
		.rd_clk  (clk_s),
		.rd_en   (axi_rvalid_s && axi_rready_s),
		.rd_data (axi_rdata_s),
		.empty   (r_empty)
	);
	assign m.rready     = !r_full;
	assign axi_rvalid_s = !r_empty;

	// Upstream master must keep aw steady while stalled
	a_aw_stable: assert property (@(posedge clk_s) disable iff (!arst_n)
		axi_awvalid_s && !axi_awready_s |=>
			axi_awvalid_s && $stable(axi_awaddr_s) && $stable(axi_awlen_s))
		else $error("axi_awvalid_s dropped or changed before axi_awready_s");

endmodule

//--- rtl/async_fifo.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Dual-clock FIFO with Gray-coded pointers
// First-word fall-through on the read side
// DEPTH must be a power of two, at least 2
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

module async_fifo #(
	parameter int WIDTH = 32,
	parameter int DEPTH = 8
) (
	input  logic             arst_n,
	input  logic             wr_clk,
	input  logic             wr_en,
	input  logic [WIDTH-1:0] wr_data,
	output logic             full,
	input  logic             rd_clk,
	input  logic             rd_en,
	output logic [WIDTH-1:0] rd_data,
	output logic             empty
);
	localparam int AW = $clog2(DEPTH); // Storage index bits

	if (DEPTH < 2 || (DEPTH & (DEPTH - 1)) != 0) begin : g_depth_check
		$fatal(1, "async_fifo DEPTH %0d is not a power of two >= 2", DEPTH);
	end

	logic [WIDTH-1:0] mem [DEPTH];

	logic [AW:0] wr_bin;      // Extra MSB tells wrap
	logic [AW:0] wr_gray;
	logic [AW:0] wr_bin_nxt;
	logic [AW:0] rd_bin;
	logic [AW:0] rd_gray;
	logic [AW:0] rd_bin_nxt;
	logic [AW:0] rd_gray_s1;  // Read pointer seen by writer
	logic [AW:0] rd_gray_s2;
	logic [AW:0] wr_gray_s1;  // Write pointer seen by reader
	logic [AW:0] wr_gray_s2;
	logic        wr_fire;
	logic        rd_fire;

	function automatic logic [AW:0] gray2bin(input logic [AW:0] g);
		logic [AW:0] b;
		b[AW] = g[AW];
		for (int i = AW - 1; i >= 0; i--) begin
			b[i] = b[i + 1] ^ g[i];
		end
		return b;
	endfunction

	// Write domain
	assign wr_fire    = wr_en && !full;
	assign wr_bin_nxt = wr_bin + {{AW{1'b0}}, wr_fire};

	always_ff @(posedge wr_clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_bin     <= '0;
			wr_gray    <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end else begin
			wr_bin     <= wr_bin_nxt;
			wr_gray    <= wr_bin_nxt ^ (wr_bin_nxt >> 1); // Single bit change per step
			rd_gray_s1 <= rd_gray;    // Two-flop sync
			rd_gray_s2 <= rd_gray_s1;
		end
	end

	always_ff @(posedge wr_clk) begin
		if (wr_fire)
			mem[wr_bin[AW-1:0]] <= wr_data;
	end

	// Full once writer is a whole lap ahead
	assign full = (wr_bin - gray2bin(rd_gray_s2)) == (AW + 1)'(DEPTH);

	// Read domain
	assign rd_fire    = rd_en && !empty;
	assign rd_bin_nxt = rd_bin + {{AW{1'b0}}, rd_fire};

	always_ff @(posedge rd_clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_bin     <= '0;
			rd_gray    <= '0;
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
		end else begin
			rd_bin     <= rd_bin_nxt;
			rd_gray    <= rd_bin_nxt ^ (rd_bin_nxt >> 1);
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
		end
	end

	assign empty   = (rd_gray == wr_gray_s2);
	assign rd_data = mem[rd_bin[AW-1:0]]; // Head word, valid while !empty

	// Callers gate enables with the flags
	a_no_overflow: assert property (@(posedge wr_clk) disable iff (!arst_n) wr_en |-> !full)
		else $error("async_fifo write while full");
	a_no_underflow: assert property (@(posedge rd_clk) disable iff (!arst_n) rd_en |-> !empty)
		else $error("async_fifo read while empty");

endmodule

//--- rtl/axi_link_if.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI link on the memory clock domain
// Joins the bridge master side to the burst memory
// Only address, length, data and last are carried
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`timescale 1ns/1ps

interface axi_link_if import axi_xing_pkg::*; (
	input logic clk,    // clk_m
	input logic arst_n
);
	// Write address
	addr_t awaddr;
	len_t  awlen;
	logic  awvalid;
	logic  awready;

	// Write data
	data_t wdata;
	logic  wlast;
	logic  wvalid;
	logic  wready;

	// Write response, no code
	logic  bvalid;
	logic  bready;

	// Read address
	addr_t araddr;
	len_t  arlen;
	logic  arvalid;
	logic  arready;

	// Read data, beats counted from arlen
	data_t rdata;
	logic  rvalid;
	logic  rready;

	modport mst (
		input  clk, arst_n, awready, wready, bvalid, arready, rdata, rvalid,
		output awaddr, awlen, awvalid, wdata, wlast, wvalid, bready,
		output araddr, arlen, arvalid, rready
	);

	modport slv (
		input  clk, arst_n, awaddr, awlen, awvalid, wdata, wlast, wvalid, bready,
		input  araddr, arlen, arvalid, rready,
		output awready, wready, bvalid, arready, rdata, rvalid
	);

endinterface

//--- rtl/axi_xing_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared widths and default sizes for the AXI clock crossing
// Imported by the RTL and the testbench
// Module parameters default to these values
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package axi_xing_pkg;

	// Bus widths
	parameter int ADDR_W = 32; // Word address
	parameter int DATA_W = 32; // One beat

	// Channel FIFO depths, powers of two
	parameter int CTRL_FIFO_DEPTH = 2; // aw, ar and b
	parameter int DATA_FIFO_DEPTH = 8; // w and r

	// Backing store behind the bridge
	parameter int MEM_WORDS = 64;

	// Word address as carried on aw and ar
	typedef logic [ADDR_W-1:0] addr_t;

	// Payload of one data beat
	typedef logic [DATA_W-1:0] data_t;

	// AXI burst length, beats minus one
	typedef logic [7:0] len_t;

endpackage
